/* source/mem_issue_pkg.sv */
////////////////////
// Memory issue package
// Micro-op layout and register index sizes for the memory issue stage
////////////////////

`default_nettype none

package mem_issue_pkg;

  // Physical register file, index 0 is the hardwired "no register"
  localparam int prf_index_width = 6;
  localparam int prf_entries = 1 << prf_index_width;

  // Reorder buffer tag
  localparam int tag_width = 5;

  // Signed address offset
  localparam int offset_width = 12;

  // Renamed load or store as it leaves dispatch
  typedef struct packed {
    logic                       valid;
    logic                       is_store;
    logic                       uses_rs1;
    logic                       uses_rs2;
    logic [prf_index_width-1:0] rs1_index;
    logic [prf_index_width-1:0] rs2_index;
    // Destination, loads only
    logic [prf_index_width-1:0] rd_index;
    logic [tag_width-1:0]       tag;
    logic [offset_width-1:0]    offset;
  } mem_uop_t;

endpackage

`default_nettype wire

/* source/issue_slot.sv */
////////////////////
// Issue slot
// One queue entry holding a memory micro-op and its readiness
////////////////////

`timescale 1ns/1ns
`default_nettype none

module issue_slot (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic                                      load,
  input  logic                                      shift,
  input  logic                                      clear,
  input  mem_issue_pkg::mem_uop_t                   uop_in,
  input  mem_issue_pkg::mem_uop_t                   uop_next,
  input  logic                                      rs1_busy,
  input  logic                                      rs2_busy,
  output mem_issue_pkg::mem_uop_t                   uop,
  output logic [mem_issue_pkg::prf_index_width-1:0] rs1_index,
  output logic [mem_issue_pkg::prf_index_width-1:0] rs2_index,
  output logic                                      ready
);

  logic                    valid_q;
  mem_issue_pkg::mem_uop_t payload_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= uop_in.valid;
    end else if (shift) begin
      valid_q <= uop_next.valid;
    end else if (clear) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      payload_q <= uop_in;
    end else if (shift) begin
      payload_q <= uop_next;
    end
  end

  always_comb begin
    uop = payload_q;
    uop.valid = valid_q;
  end

  // Unused sources report register 0, which is never busy
  assign rs1_index = payload_q.uses_rs1 ? payload_q.rs1_index : '0;
  assign rs2_index = payload_q.uses_rs2 ? payload_q.rs2_index : '0;

  assign ready = valid_q && !rs1_busy && !rs2_busy;

endmodule

`default_nettype wire

/* source/issue_select.sv */
////////////////////
// Issue select
// Oldest ready slot wins, stores only from slot 0
////////////////////

`timescale 1ns/1ns
`default_nettype none

module issue_select #(
  parameter int queue_depth = 8
) (
  input  logic [queue_depth-1:0]         ready,
  input  logic [queue_depth-1:0]         is_store,
  input  logic                           mem_stall,
  output logic [$clog2(queue_depth)-1:0] select,
  output logic                           select_valid
);

  localparam int sel_width = $clog2(queue_depth);

  logic [queue_depth-1:0] candidates;

  // A store may go only once nothing older is left
  assign candidates = ready & ~{is_store[queue_depth-1:1], 1'b0};

  // Priority encoder, lowest index is oldest
  always_comb begin
    select = '0;
    select_valid = 1'b0;
    for (int i = queue_depth - 1; i >= 0; i--) begin
      if (candidates[i] && !mem_stall) begin
        select = sel_width'(i);
        select_valid = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/busy_table.sv */
////////////////////
// Busy table
// Pending-result bits per physical register
////////////////////

`timescale 1ns/1ns
`default_nettype none

module busy_table #(
  parameter int queue_depth = 8,
  parameter int dispatch_width = 2
) (
  input  logic                                                         clock,
  input  logic                                                         reset,
  input  logic [dispatch_width-1:0]                                    set_valid,
  input  logic [dispatch_width-1:0][mem_issue_pkg::prf_index_width-1:0] set_index,
  input  logic                                                         writeback_valid,
  input  logic [mem_issue_pkg::prf_index_width-1:0]                    writeback_index,
  input  logic [queue_depth-1:0][mem_issue_pkg::prf_index_width-1:0]   rs1_index,
  input  logic [queue_depth-1:0][mem_issue_pkg::prf_index_width-1:0]   rs2_index,
  output logic [queue_depth-1:0]                                       rs1_busy,
  output logic [queue_depth-1:0]                                       rs2_busy
);

  logic [mem_issue_pkg::prf_entries-1:0] busy_q;
  logic [mem_issue_pkg::prf_entries-1:0] busy_next;

  // Set after clear, so a same-edge dispatch keeps the bit busy
  always_comb begin
    busy_next = busy_q;
    if (writeback_valid) begin
      busy_next[writeback_index] = 1'b0;
    end
    for (int j = 0; j < dispatch_width; j++) begin
      if (set_valid[j]) begin
        busy_next[set_index[j]] = 1'b1;
      end
    end
    busy_next[0] = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_next;
    end
  end

  always_comb begin
    for (int i = 0; i < queue_depth; i++) begin
      rs1_busy[i] = busy_q[rs1_index[i]];
      rs2_busy[i] = busy_q[rs2_index[i]];
    end
  end

endmodule

`default_nettype wire

/* source/mem_issue_queue.sv */
////////////////////
// Memory issue queue
// Compacting age-ordered slots, one issue per cycle
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_issue_queue #(
  parameter int queue_depth = 8,
  parameter int dispatch_width = 2
) (
  input  logic                                                          clock,
  input  logic                                                          reset,
  input  mem_issue_pkg::mem_uop_t [dispatch_width-1:0]                  dispatch_uop,
  input  logic                                                          mem_stall,
  input  logic [queue_depth-1:0]                                        rs1_busy,
  input  logic [queue_depth-1:0]                                        rs2_busy,
  output logic [queue_depth-1:0][mem_issue_pkg::prf_index_width-1:0]    rs1_index,
  output logic [queue_depth-1:0][mem_issue_pkg::prf_index_width-1:0]    rs2_index,
  output logic [dispatch_width-1:0]                                     set_valid,
  output logic [dispatch_width-1:0][mem_issue_pkg::prf_index_width-1:0] set_index,
  output logic                                                          issue_valid,
  output mem_issue_pkg::mem_uop_t                                       issue_uop,
  output logic                                                          queue_full
);

  localparam int sel_width = $clog2(queue_depth);
  localparam int count_width = $clog2(queue_depth + 1);

  logic [count_width-1:0] count;
  logic [count_width-1:0] count_next;
  logic                   queue_full_next;
  logic                   accept;

  logic [queue_depth-1:0] load;
  logic [queue_depth-1:0] shift;
  logic [queue_depth-1:0] clear;
  logic [queue_depth-1:0] ready;
  logic [queue_depth-1:0] is_store;

  mem_issue_pkg::mem_uop_t [queue_depth-1:0] slot_uop;
  mem_issue_pkg::mem_uop_t [queue_depth-1:0] slot_in;
  mem_issue_pkg::mem_uop_t [queue_depth-1:0] uop_above;

  logic [sel_width-1:0] select;
  logic                 select_valid;

  for (genvar k = 0; k < queue_depth; k++) begin : g_slot
    issue_slot slot_inst (
      .clock     (clock),
      .reset     (reset),
      .load      (load[k]),
      .shift     (shift[k]),
      .clear     (clear[k]),
      .uop_in    (slot_in[k]),
      .uop_next  (uop_above[k]),
      .rs1_busy  (rs1_busy[k]),
      .rs2_busy  (rs2_busy[k]),
      .uop       (slot_uop[k]),
      .rs1_index (rs1_index[k]),
      .rs2_index (rs2_index[k]),
      .ready     (ready[k])
    );
    assign is_store[k] = slot_uop[k].is_store;
  end

  // The top slot sees an empty neighbor
  always_comb begin
    uop_above = '0;
    for (int i = 0; i + 1 < queue_depth; i++) begin
      uop_above[i] = slot_uop[i + 1];
    end
  end

  issue_select #(
    .queue_depth (queue_depth)
  ) select_inst (
    .ready        (ready),
    .is_store     (is_store),
    .mem_stall    (mem_stall),
    .select       (select),
    .select_valid (select_valid)
  );

  assign issue_valid = select_valid;
  assign issue_uop = slot_uop[select];

  // Entries from the issued slot upward pull their neighbor down
  // The highest occupied slot is left empty unless refilled
  always_comb begin
    shift = '0;
    clear = '0;
    if (select_valid) begin
      for (int i = 0; i < queue_depth; i++) begin
        shift[i] = (i >= int'(select)) && (i < int'(count) - 1);
        clear[i] = (i == int'(count) - 1);
      end
    end
  end

  assign accept = !queue_full;

  // Valid lanes packed behind the compacted entries, lane 0 first
  always_comb begin
    logic [count_width-1:0] pos;
    pos = count - count_width'(select_valid);
    load = '0;
    slot_in = '0;
    set_valid = '0;
    set_index = '0;
    for (int j = 0; j < dispatch_width; j++) begin
      set_index[j] = dispatch_uop[j].rd_index;
      if (accept && dispatch_uop[j].valid) begin
        for (int i = 0; i < queue_depth; i++) begin
          if (i == int'(pos)) begin
            load[i] = 1'b1;
            slot_in[i] = dispatch_uop[j];
          end
        end
        set_valid[j] = !dispatch_uop[j].is_store && (dispatch_uop[j].rd_index != '0);
        pos = pos + 1'b1;
      end
    end
    count_next = pos;
  end

  assign queue_full_next = int'(count_next) > queue_depth - dispatch_width;

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
      queue_full <= 1'b0;
    end else begin
      count <= count_next;
      queue_full <= queue_full_next;
    end
  end

endmodule

`default_nettype wire

/* source/mem_issue_top.sv */
////////////////////
// Memory issue stage
// Issue queue plus busy table toward address generation
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_issue_top #(
  parameter int queue_depth = 8,
  parameter int dispatch_width = 2
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  mem_issue_pkg::mem_uop_t [dispatch_width-1:0] dispatch_uop,
  input  logic                                         mem_stall,
  input  logic                                         writeback_valid,
  input  logic [mem_issue_pkg::prf_index_width-1:0]    writeback_index,
  output logic                                         issue_valid,
  output mem_issue_pkg::mem_uop_t                      issue_uop,
  output logic                                         queue_full
);

  logic [queue_depth-1:0][mem_issue_pkg::prf_index_width-1:0]    rs1_index;
  logic [queue_depth-1:0][mem_issue_pkg::prf_index_width-1:0]    rs2_index;
  logic [queue_depth-1:0]                                        rs1_busy;
  logic [queue_depth-1:0]                                        rs2_busy;
  logic [dispatch_width-1:0]                                     set_valid;
  logic [dispatch_width-1:0][mem_issue_pkg::prf_index_width-1:0] set_index;

  mem_issue_queue #(
    .queue_depth    (queue_depth),
    .dispatch_width (dispatch_width)
  ) queue_inst (
    .clock        (clock),
    .reset        (reset),
    .dispatch_uop (dispatch_uop),
    .mem_stall    (mem_stall),
    .rs1_busy     (rs1_busy),
    .rs2_busy     (rs2_busy),
    .rs1_index    (rs1_index),
    .rs2_index    (rs2_index),
    .set_valid    (set_valid),
    .set_index    (set_index),
    .issue_valid  (issue_valid),
    .issue_uop    (issue_uop),
    .queue_full   (queue_full)
  );

  busy_table #(
    .queue_depth    (queue_depth),
    .dispatch_width (dispatch_width)
  ) busy_inst (
    .clock           (clock),
    .reset           (reset),
    .set_valid       (set_valid),
    .set_index       (set_index),
    .writeback_valid (writeback_valid),
    .writeback_index (writeback_index),
    .rs1_index       (rs1_index),
    .rs2_index       (rs2_index),
    .rs1_busy        (rs1_busy),
    .rs2_busy        (rs2_busy)
  );

endmodule

`default_nettype wire

/* tb/mem_issue_tb.sv */
////////////////////
// Memory issue stage testbench
// Directed tests for age order, wakeup, store rule and stall
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mem_issue_tb;

  localparam int queue_depth = 8;
  localparam int dispatch_width = 2;
  localparam int clock_period = 8;
  localparam int index_width = mem_issue_pkg::prf_index_width;

  // Cycle budget of each test
  localparam int reset_cycles = 10;
  localparam int order_cycles = 40;
  localparam int wakeup_cycles = 50;
  localparam int pass_cycles = 50;
  localparam int store_cycles = 50;
  localparam int stall_cycles = 80;
  localparam int watchdog_cycles = 4 * (reset_cycles + order_cycles + wakeup_cycles
                                        + pass_cycles + store_cycles + stall_cycles);

  logic                                         clock;
  logic                                         reset;
  mem_issue_pkg::mem_uop_t [dispatch_width-1:0] dispatch_uop;
  logic                                         mem_stall;
  logic                                         writeback_valid;
  logic [index_width-1:0]                       writeback_index;
  logic                                         issue_valid;
  mem_issue_pkg::mem_uop_t                      issue_uop;
  logic                                         queue_full;

  int                                    value_errors;
  int                                    other_errors;
  logic [mem_issue_pkg::tag_width-1:0]   next_tag;
  logic [mem_issue_pkg::prf_entries-1:0] reg_used;
  logic [mem_issue_pkg::prf_entries-1:0] reg_busy;
  mem_issue_pkg::mem_uop_t               issued[$];
  mem_issue_pkg::mem_uop_t               expected[$];

  mem_issue_top #(
    .queue_depth    (queue_depth),
    .dispatch_width (dispatch_width)
  ) dut0 (
    .clock           (clock),
    .reset           (reset),
    .dispatch_uop    (dispatch_uop),
    .mem_stall       (mem_stall),
    .writeback_valid (writeback_valid),
    .writeback_index (writeback_index),
    .issue_valid     (issue_valid),
    .issue_uop       (issue_uop),
    .queue_full      (queue_full)
  );

  always #(clock_period / 2) clock = ~clock;

  // Issue is taken at the next rising edge, so the value is stable here
  always @(negedge clock) begin
    if (!reset && issue_valid) begin
      if (sources_busy(issue_uop)) begin
        other_errors++;
        $display("ERROR at %0t: tag %0d issued while a source was still pending",
                 $time, issue_uop.tag);
      end
      issued.push_back(issue_uop);
    end
  end

  function automatic logic [index_width-1:0] fresh_reg();
    logic [31:0]            pick;
    logic [index_width-1:0] index;
    index = '0;
    while (reg_used[index]) begin
      pick = $urandom % (mem_issue_pkg::prf_entries - 1) + 1;
      index = pick[index_width-1:0];
    end
    reg_used[index] = 1'b1;
    return index;
  endfunction

  function automatic mem_issue_pkg::mem_uop_t make_uop(input logic is_store,
      input logic [index_width-1:0] rs1, input logic [index_width-1:0] rs2,
      input logic [index_width-1:0] rd);
    mem_issue_pkg::mem_uop_t uop;
    logic [31:0]             pick;
    pick = $urandom;
    uop = '0;
    uop.valid = 1'b1;
    uop.is_store = is_store;
    uop.uses_rs1 = 1'b1;
    uop.uses_rs2 = is_store;
    uop.rs1_index = rs1;
    uop.rs2_index = rs2;
    uop.rd_index = rd;
    uop.tag = next_tag;
    uop.offset = pick[mem_issue_pkg::offset_width-1:0];
    next_tag++;
    return uop;
  endfunction

  function automatic logic sources_busy(input mem_issue_pkg::mem_uop_t uop);
    return (uop.uses_rs1 && reg_busy[uop.rs1_index]) || (uop.uses_rs2 && reg_busy[uop.rs2_index]);
  endfunction

  task automatic check_uop(input string name, input mem_issue_pkg::mem_uop_t actual,
      input mem_issue_pkg::mem_uop_t wanted);
    if (actual !== wanted) begin
      value_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, wanted);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic wanted);
    if (actual !== wanted) begin
      value_errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, wanted);
    end
  endtask

  task automatic dispatch(input mem_issue_pkg::mem_uop_t lane0,
      input mem_issue_pkg::mem_uop_t lane1);
    @(posedge clock);
    dispatch_uop[0] <= lane0;
    dispatch_uop[1] <= lane1;
    @(posedge clock);
    dispatch_uop <= '0;
    // Loads mark their destination pending
    if (lane0.valid && !lane0.is_store) begin
      reg_busy[lane0.rd_index] = 1'b1;
    end
    if (lane1.valid && !lane1.is_store) begin
      reg_busy[lane1.rd_index] = 1'b1;
    end
  endtask

  task automatic writeback(input logic [index_width-1:0] index);
    @(posedge clock);
    writeback_valid <= 1'b1;
    writeback_index <= index;
    @(posedge clock);
    writeback_valid <= 1'b0;
    reg_busy[index] = 1'b0;
  endtask

  task automatic wait_issues(input int count, input int limit);
    int waited;
    waited = 0;
    while (issued.size() < count && waited < limit) begin
      @(posedge clock);
      waited++;
    end
    if (issued.size() < count) begin
      other_errors++;
      $display("ERROR at %0t: only %0d of %0d issues seen within %0d cycles",
               $time, issued.size(), count, limit);
    end
  endtask

  // Entry must stay in the queue for a while
  task automatic check_held(input mem_issue_pkg::mem_uop_t uop, input int cycles,
      input string reason);
    repeat (cycles) @(posedge clock);
    foreach (issued[i]) begin
      if (issued[i].tag == uop.tag) begin
        other_errors++;
        $display("ERROR at %0t: tag %0d issued %s", $time, uop.tag, reason);
      end
    end
  endtask

  task automatic check_order(input string name);
    repeat (4) @(posedge clock);
    if (issued.size() != expected.size()) begin
      other_errors++;
      $display("ERROR at %0t: %s saw %0d issues where %0d were due",
               $time, name, issued.size(), expected.size());
    end
    for (int i = 0; i < issued.size() && i < expected.size(); i++) begin
      check_uop($sformatf("%s issue_uop %0d", name, i), issued[i], expected[i]);
    end
    issued.delete();
    expected.delete();
  endtask

  task automatic test_reset();
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b0);
    check_bit("queue_full", queue_full, 1'b0);
  endtask

  task automatic test_age_order();
    mem_issue_pkg::mem_uop_t uops[4];
    foreach (uops[i]) begin
      uops[i] = make_uop(1'b0, fresh_reg(), '0, fresh_reg());
      expected.push_back(uops[i]);
    end
    dispatch(uops[0], uops[1]);
    dispatch(uops[2], uops[3]);
    wait_issues(4, order_cycles / 2);
    check_order("age order");
  endtask

  task automatic test_wakeup();
    mem_issue_pkg::mem_uop_t producer;
    mem_issue_pkg::mem_uop_t consumer;
    logic [index_width-1:0]  shared;
    shared = fresh_reg();
    producer = make_uop(1'b0, fresh_reg(), '0, shared);
    consumer = make_uop(1'b0, shared, '0, fresh_reg());
    dispatch(producer, '0);
    dispatch(consumer, '0);
    wait_issues(1, 20);
    check_held(consumer, 6, "before the writeback of its source");
    writeback(shared);
    wait_issues(2, 20);
    expected.push_back(producer);
    expected.push_back(consumer);
    check_order("dependency wakeup");
  endtask

  task automatic test_younger_passes();
    mem_issue_pkg::mem_uop_t producer;
    mem_issue_pkg::mem_uop_t blocked;
    mem_issue_pkg::mem_uop_t younger;
    logic [index_width-1:0]  shared;
    shared = fresh_reg();
    producer = make_uop(1'b0, fresh_reg(), '0, shared);
    blocked = make_uop(1'b0, shared, '0, fresh_reg());
    younger = make_uop(1'b0, fresh_reg(), '0, fresh_reg());
    dispatch(producer, blocked);
    dispatch(younger, '0);
    wait_issues(2, 20);
    check_held(blocked, 6, "before the writeback of its source");
    writeback(shared);
    wait_issues(3, 20);
    expected.push_back(producer);
    expected.push_back(younger);
    expected.push_back(blocked);
    check_order("younger load passes");
  endtask

  task automatic test_store_oldest();
    mem_issue_pkg::mem_uop_t producer;
    mem_issue_pkg::mem_uop_t blocked;
    mem_issue_pkg::mem_uop_t store;
    logic [index_width-1:0]  shared;
    shared = fresh_reg();
    producer = make_uop(1'b0, fresh_reg(), '0, shared);
    blocked = make_uop(1'b0, shared, '0, fresh_reg());
    store = make_uop(1'b1, fresh_reg(), fresh_reg(), '0);
    dispatch(producer, blocked);
    dispatch(store, '0);
    wait_issues(1, 20);
    check_held(store, 8, "while an older load was still queued");
    writeback(shared);
    wait_issues(3, 20);
    expected.push_back(producer);
    expected.push_back(blocked);
    expected.push_back(store);
    check_order("store waits until oldest");
  endtask

  task automatic test_stall_full();
    mem_issue_pkg::mem_uop_t lane0;
    mem_issue_pkg::mem_uop_t lane1;
    int                      accepted;
    accepted = 0;
    @(posedge clock);
    mem_stall <= 1'b1;
    @(negedge clock);
    while (!queue_full && accepted < queue_depth) begin
      lane0 = make_uop(1'b0, fresh_reg(), '0, fresh_reg());
      lane1 = make_uop(1'b0, fresh_reg(), '0, fresh_reg());
      expected.push_back(lane0);
      expected.push_back(lane1);
      dispatch(lane0, lane1);
      accepted += dispatch_width;
      @(negedge clock);
      check_bit("issue_valid", issue_valid, 1'b0);
    end
    if (!queue_full || accepted <= queue_depth - dispatch_width || accepted > queue_depth) begin
      other_errors++;
      $display("ERROR at %0t: queue_full is %b after %0d accepted micro-ops",
               $time, queue_full, accepted);
    end
    repeat (3) @(negedge clock);
    check_bit("issue_valid", issue_valid, 1'b0);
    @(posedge clock);
    mem_stall <= 1'b0;
    wait_issues(accepted, stall_cycles / 2);
    @(negedge clock);
    check_bit("queue_full", queue_full, 1'b0);
    check_order("stall and full");
  endtask

  initial begin
    void'($urandom(32'he590_040b));
    clock = 1'b0;
    reset = 1'b1;
    dispatch_uop = '0;
    mem_stall = 1'b0;
    writeback_valid = 1'b0;
    writeback_index = '0;
    value_errors = 0;
    other_errors = 0;
    next_tag = '0;
    reg_used = '0;
    reg_used[0] = 1'b1;
    reg_busy = '0;
    test_reset();
    test_age_order();
    test_wakeup();
    test_younger_passes();
    test_store_oldest();
    test_stall_full();
    $display("Error count: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Watchdog expired after %0d cycles before the tests ended", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/mem_issue_pkg.sv
source/issue_slot.sv
source/issue_select.sv
source/busy_table.sv
source/mem_issue_queue.sv
source/mem_issue_top.sv
tb/mem_issue_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= mem_issue_tb
FILE_LIST ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
